// File: design/uart_line_pkg.sv
package uart_line_pkg;

   //////////////////////////////////////////////////////////////////////////
   // frame layout

   localparam int data_bits_c  = 8;   // payload bits per frame
   localparam int frame_bits_c = 10;  // start + data + stop

   // marker bit walks down the rx shift register, byte is done at bit 0
   localparam logic [data_bits_c-1:0] start_marker_c = 8'h80;

   //////////////////////////////////////////////////////////////////////////
   // state machines

   typedef enum logic [1:0] {
      rx_idle_s  = 2'b00,
      rx_start_s = 2'b01,  // waiting for middle of start bit
      rx_data_s  = 2'b11,
      rx_stop_s  = 2'b10   // riding out the stop bit
   } rx_state_e;

   typedef enum logic [1:0] {
      tx_idle_s  = 2'b00,
      tx_start_s = 2'b01,
      tx_send_s  = 2'b10   // data bits followed by stop
   } tx_state_e;

endpackage

// File: design/uart_reg_pkg.sv
package uart_reg_pkg;

   //////////////////////////////////////////////////////////////////////////
   // apb geometry

   localparam int addr_w_c = 4;
   localparam int data_w_c = 32;

   // register offsets
   localparam logic [addr_w_c-1:0] status_off_c = 4'h0;  // read only
   localparam logic [addr_w_c-1:0] txdata_off_c = 4'h4;  // write only
   localparam logic [addr_w_c-1:0] rxdata_off_c = 4'h8;  // read clears flags

   //////////////////////////////////////////////////////////////////////////
   // status word bits

   localparam int st_tx_busy_c    = 0;
   localparam int st_rx_valid_c   = 1;
   localparam int st_rx_overrun_c = 2;

endpackage

// File: design/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
   parameter int clks_per_bit = 104
) (
   input  logic                                 i_clk,
   input  logic                                 i_nrst,
   input  logic                                 i_uart_rx,
   output logic                                 o_rx_valid,
   output logic [uart_line_pkg::data_bits_c-1:0] o_rx_data
);

   localparam int cnt_w = $clog2(clks_per_bit);
   localparam logic [cnt_w-1:0] full_c = cnt_w'(clks_per_bit - 1);
   localparam logic [cnt_w-1:0] half_c = cnt_w'(clks_per_bit / 2 - 1);

   logic                                 rx_sync;
   uart_line_pkg::rx_state_e             state;
   uart_line_pkg::rx_state_e             state_next;
   logic [cnt_w-1:0]                     count;
   logic                                 half_hit;
   logic                                 full_hit;
   logic                                 start_seen;
   logic [uart_line_pkg::data_bits_c-1:0] shreg;

   ////////////////////////////////////////////////////////////////////////////
   // line synchronizer

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 1'b1;  // idle line level
      end else begin
         rx_sync <= i_uart_rx;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // state machine

   assign half_hit   = (count == half_c);
   assign full_hit   = (count == full_c);
   assign start_seen = (state == uart_line_pkg::rx_idle_s) & ~rx_sync;

   always_comb begin
      state_next = state;
      case (state)
         uart_line_pkg::rx_idle_s: begin
            if (!rx_sync) state_next = uart_line_pkg::rx_start_s;
         end
         uart_line_pkg::rx_start_s: begin
            if (half_hit) begin
               // a glitch shorter than half a bit goes back to idle
               state_next = rx_sync ? uart_line_pkg::rx_idle_s : uart_line_pkg::rx_data_s;
            end
         end
         uart_line_pkg::rx_data_s: begin
            if (full_hit && shreg[0]) state_next = uart_line_pkg::rx_stop_s;  // last bit
         end
         uart_line_pkg::rx_stop_s: begin
            if (full_hit) state_next = uart_line_pkg::rx_idle_s;
         end
         default: state_next = uart_line_pkg::rx_idle_s;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= uart_line_pkg::rx_idle_s;
      end else begin
         state <= state_next;
      end
   end

   // sample counter, restarts at each sample point
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count <= '0;
      end else if ((state == uart_line_pkg::rx_idle_s) || full_hit ||
                   ((state == uart_line_pkg::rx_start_s) && half_hit)) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // shift register, lsb arrives first

   always_ff @(posedge i_clk) begin
      if (start_seen) begin
         shreg <= uart_line_pkg::start_marker_c;
      end else if ((state == uart_line_pkg::rx_data_s) && full_hit) begin
         shreg <= {rx_sync, shreg[uart_line_pkg::data_bits_c-1:1]};
      end
   end

   assign o_rx_valid = (state == uart_line_pkg::rx_stop_s) & full_hit;
   assign o_rx_data  = shreg;

endmodule

// File: design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
   parameter int clks_per_bit = 104
) (
   input  logic                                 i_clk,
   input  logic                                 i_nrst,
   input  logic                                 i_tx_start,
   input  logic [uart_line_pkg::data_bits_c-1:0] i_tx_data,
   output logic                                 o_uart_tx,
   output logic                                 o_tx_busy
);

   localparam int cnt_w = $clog2(clks_per_bit);
   localparam int bit_w = $clog2(uart_line_pkg::frame_bits_c);
   localparam logic [cnt_w-1:0] full_c = cnt_w'(clks_per_bit - 1);
   localparam logic [bit_w-1:0] last_c = bit_w'(uart_line_pkg::frame_bits_c - 1);

   uart_line_pkg::tx_state_e             state;
   uart_line_pkg::tx_state_e             state_next;
   logic [cnt_w-1:0]                     count;
   logic [bit_w-1:0]                     bit_cnt;
   logic                                 bit_done;
   logic                                 finish;
   logic [uart_line_pkg::data_bits_c-1:0] shreg;

   ////////////////////////////////////////////////////////////////////////////
   // bit timing

   assign bit_done = (count == full_c);
   assign finish   = bit_done & (bit_cnt == last_c);  // end of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count <= '0;
      end else if ((state == uart_line_pkg::tx_idle_s) || bit_done) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // counts start, data and stop bits of the frame
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         bit_cnt <= '0;
      end else if (finish || (state == uart_line_pkg::tx_idle_s)) begin
         bit_cnt <= '0;
      end else if (bit_done) begin
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // state machine

   always_comb begin
      state_next = state;
      case (state)
         uart_line_pkg::tx_idle_s:  if (i_tx_start) state_next = uart_line_pkg::tx_start_s;
         uart_line_pkg::tx_start_s: if (bit_done) state_next = uart_line_pkg::tx_send_s;
         uart_line_pkg::tx_send_s:  if (finish) state_next = uart_line_pkg::tx_idle_s;
         default:                   state_next = uart_line_pkg::tx_idle_s;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= uart_line_pkg::tx_idle_s;
      end else begin
         state <= state_next;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // shift register

   // ones fill from the top so the stop bit falls out last
   always_ff @(posedge i_clk) begin
      if ((state == uart_line_pkg::tx_idle_s) && i_tx_start) begin
         shreg <= i_tx_data;
      end else if ((state == uart_line_pkg::tx_send_s) && bit_done) begin
         shreg <= {1'b1, shreg[uart_line_pkg::data_bits_c-1:1]};
      end
   end

   always_comb begin
      case (state)
         uart_line_pkg::tx_idle_s:  o_uart_tx = 1'b1;
         uart_line_pkg::tx_start_s: o_uart_tx = 1'b0;
         default:                   o_uart_tx = shreg[0];
      endcase
   end

   assign o_tx_busy = (state != uart_line_pkg::tx_idle_s);

endmodule

// File: design/uart_apb_regs.sv
`timescale 1ns/10ps

module uart_apb_regs (
   input  logic                                 i_clk,
   input  logic                                 i_nrst,
   input  logic                                 i_psel,
   input  logic                                 i_penable,
   input  logic                                 i_pwrite,
   input  logic [uart_reg_pkg::addr_w_c-1:0]     i_paddr,
   input  logic [uart_reg_pkg::data_w_c-1:0]     i_pwdata,
   output logic [uart_reg_pkg::data_w_c-1:0]     o_prdata,
   output logic                                 o_pready,
   output logic                                 o_pslverr,
   input  logic                                 i_rx_valid,
   input  logic [uart_line_pkg::data_bits_c-1:0] i_rx_data,
   input  logic                                 i_tx_busy,
   output logic                                 o_tx_start,
   output logic [uart_line_pkg::data_bits_c-1:0] o_tx_data
);

   logic                                 access;
   logic                                 sel_status;
   logic                                 sel_tx;
   logic                                 sel_rx;
   logic                                 mapped;
   logic                                 wr_err;
   logic                                 rd_rx;
   logic                                 rx_valid;
   logic                                 rx_overrun;
   logic [uart_line_pkg::data_bits_c-1:0] rx_byte;
   logic [uart_reg_pkg::data_w_c-1:0]     status;

   ////////////////////////////////////////////////////////////////////////////
   // decode

   assign access     = i_psel & i_penable;  // second cycle of a transfer
   assign sel_status = (i_paddr == uart_reg_pkg::status_off_c);
   assign sel_tx     = (i_paddr == uart_reg_pkg::txdata_off_c);
   assign sel_rx     = (i_paddr == uart_reg_pkg::rxdata_off_c);
   assign mapped     = sel_status | sel_tx | sel_rx;

   // only txdata takes writes, and only while the line is free
   assign wr_err = ~sel_tx | i_tx_busy;

   assign o_pready  = 1'b1;  // no wait states
   assign o_pslverr = access & (i_pwrite ? wr_err : ~mapped);

   ////////////////////////////////////////////////////////////////////////////
   // transmit path

   assign o_tx_start = access & i_pwrite & sel_tx & ~i_tx_busy;
   assign o_tx_data  = i_pwdata[uart_line_pkg::data_bits_c-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // receive holding register

   assign rd_rx = access & ~i_pwrite & sel_rx;

   always_ff @(posedge i_clk) begin
      if (i_rx_valid) begin
         rx_byte <= i_rx_data;  // newest byte always wins
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_valid   <= 1'b0;
         rx_overrun <= 1'b0;
      end else if (i_rx_valid) begin
         rx_valid <= 1'b1;
         // a read in the same cycle consumed the old byte
         if (rd_rx) begin
            rx_overrun <= 1'b0;
         end else if (rx_valid) begin
            rx_overrun <= 1'b1;
         end
      end else if (rd_rx) begin
         rx_valid   <= 1'b0;
         rx_overrun <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read data

   always_comb begin
      status                                = '0;
      status[uart_reg_pkg::st_tx_busy_c]    = i_tx_busy;
      status[uart_reg_pkg::st_rx_valid_c]   = rx_valid;
      status[uart_reg_pkg::st_rx_overrun_c] = rx_overrun;
   end

   always_comb begin
      o_prdata = '0;  // txdata and holes read as zero
      if (sel_status) begin
         o_prdata = status;
      end else if (sel_rx) begin
         o_prdata[uart_line_pkg::data_bits_c-1:0] = rx_byte;
      end
   end

endmodule

// File: design/uart_periph.sv
`timescale 1ns/10ps

module uart_periph #(
   parameter int clks_per_bit = 104
) (
   input  logic                             i_clk,
   input  logic                             i_nrst,
   // apb slave
   input  logic                             i_psel,
   input  logic                             i_penable,
   input  logic                             i_pwrite,
   input  logic [uart_reg_pkg::addr_w_c-1:0] i_paddr,
   input  logic [uart_reg_pkg::data_w_c-1:0] i_pwdata,
   output logic [uart_reg_pkg::data_w_c-1:0] o_prdata,
   output logic                             o_pready,
   output logic                             o_pslverr,
   // serial line
   input  logic                             i_uart_rx,
   output logic                             o_uart_tx
);

   logic                                 rx_valid;
   logic [uart_line_pkg::data_bits_c-1:0] rx_data;
   logic                                 tx_busy;
   logic                                 tx_start;
   logic [uart_line_pkg::data_bits_c-1:0] tx_data;

   uart_apb_regs uart_apb_regs_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pwdata   (i_pwdata),
      .o_prdata   (o_prdata),
      .o_pready   (o_pready),
      .o_pslverr  (o_pslverr),
      .i_rx_valid (rx_valid),
      .i_rx_data  (rx_data),
      .i_tx_busy  (tx_busy),
      .o_tx_start (tx_start),
      .o_tx_data  (tx_data)
   );

   uart_rx #(
      .clks_per_bit (clks_per_bit)
   ) uart_rx_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_uart_rx  (i_uart_rx),
      .o_rx_valid (rx_valid),
      .o_rx_data  (rx_data)
   );

   uart_tx #(
      .clks_per_bit (clks_per_bit)
   ) uart_tx_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_start (tx_start),
      .i_tx_data  (tx_data),
      .o_uart_tx  (o_uart_tx),
      .o_tx_busy  (tx_busy)
   );

endmodule

// File: verif/tb_uart_tasks.svh
`ifndef tb_uart_tasks_svh
`define tb_uart_tasks_svh

localparam logic [7:0] lfsr_seed = 8'd56;

logic [7:0] lfsr_state = lfsr_seed;

////////////////////////////////////////////////////////////////////////////
// checking

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
   if (got !== expected) begin
      $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, expected);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
   end
endtask

////////////////////////////////////////////////////////////////////////////
// apb master

task automatic apb_transfer(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
   @(posedge clk);
   #(drive_ns);
   psel    = 1'b1;  // setup cycle
   penable = 1'b0;
   pwrite  = write;
   paddr   = addr;
   pwdata  = wdata;
   @(posedge clk);
   #(drive_ns);
   penable = 1'b1;
   #(clk_period_ns / 2);  // middle of access cycle
   rdata = prdata;
   err   = pslverr;
   check_value("o_pready", 32'(pready), 32'h1);
   @(posedge clk);
   #(drive_ns);
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata,
                         output logic err);
   logic [31:0] unused_rdata;
   apb_transfer(1'b1, addr, wdata, unused_rdata, err);
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
                        output logic err);
   apb_transfer(1'b0, addr, 32'h0, rdata, err);
endtask

// reads status until the masked bits match, bounded
task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
                           input string what);
   logic [31:0] rdata;
   logic        err;
   int          polls;
   polls = 0;
   apb_read(status_off, rdata, err);
   while ((rdata & mask) != want) begin
      if (polls == max_polls) begin
         $display("status never showed the %s after %0d reads", what, polls);
         $display("Verification failed");
         $fatal(1, "status poll limit reached");
      end else begin
         polls++;
         apb_read(status_off, rdata, err);
      end
   end
endtask

////////////////////////////////////////////////////////////////////////////
// serial line

task automatic send_frame(input logic [7:0] data);
   logic [frame_bits-1:0] bits;
   bits = {1'b1, data, 1'b0};  // stop, data lsb first, start
   @(posedge clk);
   for (int i = 0; i < frame_bits; i++) begin
      #(drive_ns);
      uart_rx = bits[i];
      repeat (clks_per_bit) @(posedge clk);
   end
endtask

task automatic recv_frame(output logic [7:0] data, output logic stop);
   @(negedge uart_tx);
   #(bit_ns / 2);  // centre of start bit
   check_value("o_uart_tx start bit", 32'(uart_tx), 32'h0);
   for (int i = 0; i < 8; i++) begin
      #(bit_ns);
      data[i] = uart_tx;
   end
   #(bit_ns);
   stop = uart_tx;
endtask

////////////////////////////////////////////////////////////////////////////
// test bytes

// galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
function automatic logic [7:0] lfsr_next(input logic [7:0] s);
   logic [7:0] n;
   n = s >> 1;
   if (s[0]) n = n ^ 8'hb8;
   return n;
endfunction

task automatic random_byte(output logic [7:0] b);
   for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      b[i] = lfsr_state[0];
   end
endtask

`endif

// File: verif/tb_uart_periph.sv
`timescale 1ns/10ps

module tb_uart_periph;

   localparam int clks_per_bit  = 16;
   localparam int clk_period_ns = 20;
   localparam int drive_ns      = 2;
   localparam int bit_ns        = clks_per_bit * clk_period_ns;
   localparam int frame_bits    = 10;
   localparam int frame_count   = 5;  // tx, busy, rx, two for overrun
   localparam int margin_ns     = 10000;
   localparam int watchdog_ns   =
      2 * frame_count * frame_bits * clks_per_bit * clk_period_ns + margin_ns;
   localparam int max_polls     = frame_bits * clks_per_bit;

   // register map as seen from the bus
   localparam logic [3:0]  status_off     = 4'h0;
   localparam logic [3:0]  txdata_off     = 4'h4;
   localparam logic [3:0]  rxdata_off     = 4'h8;
   localparam logic [3:0]  hole_off       = 4'hc;
   localparam logic [31:0] tx_busy_bit    = 32'h1;
   localparam logic [31:0] rx_valid_bit   = 32'h2;
   localparam logic [31:0] rx_overrun_bit = 32'h4;

   logic        clk;
   logic        nrst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        uart_rx;
   logic        uart_tx;

   `include "tb_uart_tasks.svh"

   uart_periph #(
      .clks_per_bit (clks_per_bit)
   ) uart_periph_inst (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pready  (pready),
      .o_pslverr (pslverr),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period_ns / 2) clk = ~clk;
   end

   initial begin
      #(watchdog_ns);
      $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic test_reset();
      logic [31:0] rdata;
      logic        err;
      check_value("o_uart_tx", 32'(uart_tx), 32'h1);
      check_value("o_pslverr", 32'(pslverr), 32'h0);
      apb_read(status_off, rdata, err);
      check_value("status", rdata, 32'h0);
      check_value("o_pslverr", 32'(err), 32'h0);
   endtask

   // a second write while busy must bounce and leave the frame alone
   task automatic test_transmit(input logic try_busy_write);
      logic [7:0]  tx_byte;
      logic [7:0]  line_byte;
      logic        stop;
      logic        err;
      logic [31:0] rdata;
      random_byte(tx_byte);
      fork
         recv_frame(line_byte, stop);
         begin
            apb_write(txdata_off, 32'(tx_byte), err);
            check_value("o_pslverr", 32'(err), 32'h0);
            apb_read(status_off, rdata, err);
            check_value("status tx_busy", rdata & tx_busy_bit, tx_busy_bit);
            if (try_busy_write) begin
               apb_write(txdata_off, 32'(tx_byte ^ 8'hff), err);
               check_value("busy write o_pslverr", 32'(err), 32'h1);
            end
         end
      join
      check_value("o_uart_tx byte", 32'(line_byte), 32'(tx_byte));
      check_value("o_uart_tx stop bit", 32'(stop), 32'h1);
      poll_status(tx_busy_bit, 32'h0, "transmitter going idle");
      apb_read(status_off, rdata, err);
      check_value("status", rdata, 32'h0);
   endtask

   task automatic test_receive();
      logic [7:0]  rx_byte;
      logic        err;
      logic [31:0] rdata;
      random_byte(rx_byte);
      send_frame(rx_byte);
      poll_status(rx_valid_bit, rx_valid_bit, "received byte");
      apb_read(rxdata_off, rdata, err);
      check_value("rxdata", rdata, 32'(rx_byte));
      check_value("o_pslverr", 32'(err), 32'h0);
      apb_read(status_off, rdata, err);
      check_value("status rx flags", rdata & (rx_valid_bit | rx_overrun_bit), 32'h0);
   endtask

   task automatic test_overrun();
      logic [7:0]  first_byte;
      logic [7:0]  second_byte;
      logic        err;
      logic [31:0] rdata;
      logic [31:0] flags;
      flags = rx_valid_bit | rx_overrun_bit;
      random_byte(first_byte);
      random_byte(second_byte);
      send_frame(first_byte);
      send_frame(second_byte);
      poll_status(flags, flags, "overrun flag");
      apb_read(status_off, rdata, err);
      check_value("status rx flags", rdata & flags, flags);
      apb_read(rxdata_off, rdata, err);
      check_value("rxdata", rdata, 32'(second_byte));  // newer byte wins
      apb_read(status_off, rdata, err);
      check_value("status rx flags", rdata & flags, 32'h0);
   endtask

   // everything is idle here, so status must stay all zero
   task automatic test_bad_access();
      logic [31:0] rdata;
      logic        err;
      apb_read(hole_off, rdata, err);
      check_value("unmapped prdata", rdata, 32'h0);
      check_value("unmapped o_pslverr", 32'(err), 32'h1);
      apb_write(status_off, 32'hffff_ffff, err);
      check_value("status write o_pslverr", 32'(err), 32'h1);
      apb_read(status_off, rdata, err);
      check_value("status", rdata, 32'h0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sequence

   initial begin
      nrst    = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      uart_rx = 1'b1;  // idle line
      repeat (2) @(posedge clk);
      #(drive_ns);
      nrst = 1'b1;
      test_reset();
      test_transmit(1'b0);
      test_transmit(1'b1);
      test_receive();
      test_overrun();
      test_bad_access();
      $display("Verification passed");
      $finish;
   end

endmodule

// File: build.f
+incdir+verif
design/uart_line_pkg.sv
design/uart_reg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_apb_regs.sv
design/uart_periph.sv
verif/tb_uart_periph.sv

// File: run.sh
#!/usr/bin/env bash
# builds the uart_periph testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_uart_periph \
   -f build.f \
   -o tb_uart_periph

./obj_dir/tb_uart_periph
